// File: project.f
hw/sram_ctrl_pkg.sv
hw/port_arbiter.sv
hw/sram_cycle.sv
hw/mcr_port.sv
hw/word_port.sv
hw/sram_ctrl_top.sv
verification/tb_clock.sv
verification/sram_model.sv
verification/sram_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SRAM controller testbench with Verilator.
# The run counts as passed only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 -f project.f --top-module sram_ctrl_tb
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/Vsram_ctrl_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Testbench passed$" "$log"; then
   exit 0
fi
echo "pass line not found in $log"
exit 1

// File: verification/sram_ctrl_tb.sv
// all ports on one clock; writes only to mapped main-memory addresses, reads only of written words
`timescale 1ns/1ps
`default_nettype none

module handshake_check #(
   parameter string port_name = "port"
)
(
   input  logic clk,
   input  logic reset,
   input  logic rd_req,
   input  logic wr_req,
   input  logic ready,
   input  logic done,
   output int   fail_count
);

   int n_fail;

   assign fail_count = n_fail;

   a_ready_rise: assert property (@(posedge clk) disable iff (reset)
      $rose(ready) |-> rd_req)
      else
      begin
         $display("%0s ready rose with no read request", port_name);
         n_fail = n_fail + 1;
      end

   a_done_rise: assert property (@(posedge clk) disable iff (reset)
      $rose(done) |-> wr_req)
      else
      begin
         $display("%0s done rose with no write request", port_name);
         n_fail = n_fail + 1;
      end

   // one cycle of grace after the request drops
   a_ready_fall: assert property (@(posedge clk) disable iff (reset)
      !rd_req && !$past(rd_req) |-> !ready)
      else
      begin
         $display("%0s ready still high after the read request dropped", port_name);
         n_fail = n_fail + 1;
      end

   a_done_fall: assert property (@(posedge clk) disable iff (reset)
      !wr_req && !$past(wr_req) |-> !done)
      else
      begin
         $display("%0s done still high after the write request dropped", port_name);
         n_fail = n_fail + 1;
      end

endmodule

module sram_ctrl_tb
   import sram_ctrl_pkg::*;
();

   localparam int p_mcr  = 0;
   localparam int p_mem  = 1;
   localparam int p_vram = 2;
   // operations issued by all tests together
   localparam int n_ops      = 100;
   localparam int max_cycles = 40 * n_ops + 100;

   logic                   clk;
   logic                   reset;
   logic                   mcr_rd_req, mcr_wr_req, mcr_ready, mcr_done;
   logic [mcr_addr_w-1:0]  mcr_addr;
   logic [mcr_data_w-1:0]  mcr_wdata, mcr_rdata, exp_mcr;
   logic                   mem_rd_req, mem_wr_req, mem_ready, mem_done;
   logic [mem_addr_w-1:0]  mem_addr;
   logic [sram_data_w-1:0] mem_wdata, mem_rdata, exp_mem;
   logic                   vram_rd_req, vram_wr_req, vram_ready, vram_done;
   logic [vram_addr_w-1:0] vram_addr;
   logic [sram_data_w-1:0] vram_wdata, vram_rdata, exp_vram;
   logic [sram_data_w-1:0] sram_din;
   sram_pins_t             sram_pins;

   // scoreboards by port address
   logic [mcr_data_w-1:0]  mcr_sb  [0:(1<<mcr_addr_w)-1];
   logic [sram_data_w-1:0] mem_sb  [0:(1<<mem_map_w)-1];
   logic [sram_data_w-1:0] vram_sb [0:(1<<vram_addr_w)-1];

   logic [31:0] lfsr = 32'h1f54;
   logic        req_seen;
   int          errors;
   int          pin_errors;
   int          err_mark;
   int          tests;
   int          cycles;
   int          hs_mcr_fails, hs_mem_fails, hs_vram_fails;

   tb_clock u_clock (.clk(clk), .reset(reset));

   sram_ctrl_top UUT (
      .clk(clk), .reset(reset),
      .mcr_rd_req(mcr_rd_req), .mcr_wr_req(mcr_wr_req), .mcr_addr(mcr_addr),
      .mcr_wdata(mcr_wdata), .mcr_rdata(mcr_rdata), .mcr_ready(mcr_ready), .mcr_done(mcr_done),
      .mem_rd_req(mem_rd_req), .mem_wr_req(mem_wr_req), .mem_addr(mem_addr),
      .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ready(mem_ready), .mem_done(mem_done),
      .vram_rd_req(vram_rd_req), .vram_wr_req(vram_wr_req), .vram_addr(vram_addr),
      .vram_wdata(vram_wdata), .vram_rdata(vram_rdata), .vram_ready(vram_ready),
      .vram_done(vram_done), .sram_din(sram_din), .sram(sram_pins)
   );

   sram_model u_sram (.clk(clk), .pins(sram_pins), .din(sram_din));

   handshake_check #(.port_name("mcr")) hs_mcr (
      .clk(clk), .reset(reset), .rd_req(mcr_rd_req), .wr_req(mcr_wr_req),
      .ready(mcr_ready), .done(mcr_done), .fail_count(hs_mcr_fails)
   );
   handshake_check #(.port_name("mem")) hs_mem (
      .clk(clk), .reset(reset), .rd_req(mem_rd_req), .wr_req(mem_wr_req),
      .ready(mem_ready), .done(mem_done), .fail_count(hs_mem_fails)
   );
   handshake_check #(.port_name("vram")) hs_vram (
      .clk(clk), .reset(reset), .rd_req(vram_rd_req), .wr_req(vram_wr_req),
      .ready(vram_ready), .done(vram_done), .fail_count(hs_vram_fails)
   );

   // ------------------------------------------------------------
   // read data and pin checks
   // ------------------------------------------------------------
   a_mcr_data: assert property (@(posedge clk) disable iff (reset)
      mcr_ready |-> mcr_rdata == exp_mcr)
      else
      begin
         $display("mismatch mcr_rdata got %h expected %h", $sampled(mcr_rdata), $sampled(exp_mcr));
         errors = errors + 1;
      end

   a_mem_data: assert property (@(posedge clk) disable iff (reset)
      mem_ready |-> mem_rdata == exp_mem)
      else
      begin
         $display("mismatch mem_rdata got %h expected %h", $sampled(mem_rdata), $sampled(exp_mem));
         errors = errors + 1;
      end

   a_vram_data: assert property (@(posedge clk) disable iff (reset)
      vram_ready |-> vram_rdata == exp_vram)
      else
      begin
         $display("mismatch vram_rdata got %h expected %h", $sampled(vram_rdata),
                  $sampled(exp_vram));
         errors = errors + 1;
      end

   a_pins_idle: assert property (@(posedge clk) disable iff (reset)
      !req_seen |-> sram_pins.ce_n && sram_pins.oe_n && sram_pins.we_n)
      else
      begin
         $display("sram strobes went active before any request");
         pin_errors = pin_errors + 1;
      end

   a_oe_we: assert property (@(posedge clk) disable iff (reset)
      sram_pins.oe_n || sram_pins.we_n)
      else
      begin
         $display("sram oe_n and we_n both low");
         pin_errors = pin_errors + 1;
      end

   always @(posedge clk)
   begin
      if (reset)
         req_seen <= 1'b0;
      else if (mcr_rd_req || mcr_wr_req || mem_rd_req || mem_wr_req || vram_rd_req || vram_wr_req)
         req_seen <= 1'b1;
   end

   // watchdog
   always @(posedge clk)
   begin
      if (reset)
         cycles <= 0;
      else
         cycles <= cycles + 1;
      if (cycles >= max_cycles)
      begin
         $display("timeout after %0d cycles with a port still waiting", cycles);
         $display("Testbench failed");
         $finish;
      end
   end

   // ------------------------------------------------------------
   // stimulus helpers
   // ------------------------------------------------------------
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // one lfsr step per bit
   task automatic take_bits(input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v    = {v[62:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   function automatic int error_total();
      return errors + pin_errors + hs_mcr_fails + hs_mem_fails + hs_vram_fails;
   endfunction

   function automatic logic flag_of(input int port, input logic wr);
      case (port)
         p_mcr:   return wr ? mcr_done : mcr_ready;
         p_mem:   return wr ? mem_done : mem_ready;
         default: return wr ? vram_done : vram_ready;
      endcase
   endfunction

   task automatic set_req(input int port, input logic rd, input logic wr);
      case (port)
         p_mcr:
         begin
            mcr_rd_req <= rd;
            mcr_wr_req <= wr;
         end
         p_mem:
         begin
            mem_rd_req <= rd;
            mem_wr_req <= wr;
         end
         default:
         begin
            vram_rd_req <= rd;
            vram_wr_req <= wr;
         end
      endcase
   endtask

   // full handshake; expected read data follows the region rules
   task automatic port_op(input int port, input logic wr, input logic [21:0] a,
                          input logic [48:0] d);
      @(posedge clk);
      case (port)
         p_mcr:
         begin
            mcr_addr  <= a[mcr_addr_w-1:0];
            mcr_wdata <= d;
            if (wr)
               mcr_sb[a[mcr_addr_w-1:0]] = d;
            else
               exp_mcr <= mcr_sb[a[mcr_addr_w-1:0]];
         end
         p_mem:
         begin
            mem_addr  <= a;
            mem_wdata <= d[31:0];
            if (wr)
               mem_sb[a[mem_map_w-1:0]] = d[31:0];
            else if (a[mem_addr_w-1:mem_map_w] != '0)
               exp_mem <= '1;
            else
               exp_mem <= mem_sb[a[mem_map_w-1:0]];
         end
         default:
         begin
            vram_addr  <= a[vram_addr_w-1:0];
            vram_wdata <= d[31:0];
            if (wr)
               vram_sb[a[vram_addr_w-1:0]] = d[31:0];
            else
               exp_vram <= vram_sb[a[vram_addr_w-1:0]];
         end
      endcase
      set_req(port, !wr, wr);
      do
         @(posedge clk);
      while (!flag_of(port, wr));
      set_req(port, 1'b0, 1'b0);
      do
         @(posedge clk);
      while (flag_of(port, wr));
   endtask

   task automatic end_test(input string name);
      $display("test %0s finished with %0d errors", name, error_total() - err_mark);
      err_mark = error_total();
      tests    = tests + 1;
   endtask

   // ------------------------------------------------------------
   // tests
   // ------------------------------------------------------------
   task automatic word_rw_test();
      logic [63:0] a;
      logic [63:0] d;
      for (int i = 0; i < 8; i++)
      begin
         take_bits(mem_map_w, a);
         take_bits(sram_data_w, d);
         port_op(p_mem, 1'b1, {5'b0, a[16:0]}, {17'b0, d[31:0]});
         port_op(p_mem, 1'b0, {5'b0, a[16:0]}, '0);
         take_bits(vram_addr_w, a);
         take_bits(sram_data_w, d);
         port_op(p_vram, 1'b1, {7'b0, a[14:0]}, {17'b0, d[31:0]});
         port_op(p_vram, 1'b0, {7'b0, a[14:0]}, '0);
      end
   endtask

   task automatic mem_range_test();
      logic [63:0] h;
      logic [63:0] a;
      for (int i = 0; i < 4; i++)
      begin
         take_bits(5, h);
         if (h[4:0] == 5'b0)
            h = 64'd1;
         take_bits(mem_map_w, a);
         port_op(p_mem, 1'b0, {h[4:0], a[16:0]}, '0);
      end
   endtask

   task automatic mcr_test();
      logic [63:0] a;
      logic [63:0] d;
      for (int i = 0; i < 8; i++)
      begin
         take_bits(mcr_addr_w, a);
         take_bits(mcr_data_w, d);
         port_op(p_mcr, 1'b1, {8'b0, a[13:0]}, d[48:0]);
         port_op(p_mcr, 1'b0, {8'b0, a[13:0]}, '0);
      end
   endtask

   // same low address bits on every port
   task automatic region_test();
      logic [63:0] x;
      logic [63:0] d;
      for (int i = 0; i < 4; i++)
      begin
         take_bits(mcr_addr_w, x);
         take_bits(sram_data_w, d);
         port_op(p_mem, 1'b1, {8'b0, x[13:0]}, {17'b0, d[31:0]});
         take_bits(sram_data_w, d);
         port_op(p_vram, 1'b1, {8'b0, x[13:0]}, {17'b0, d[31:0]});
         take_bits(mcr_data_w, d);
         port_op(p_mcr, 1'b1, {8'b0, x[13:0]}, d[48:0]);
         port_op(p_mem, 1'b0, {8'b0, x[13:0]}, '0);
         port_op(p_vram, 1'b0, {8'b0, x[13:0]}, '0);
         port_op(p_mcr, 1'b0, {8'b0, x[13:0]}, '0);
      end
   endtask

   task automatic concurrent_test();
      logic [63:0] ma, va, ca;
      logic [63:0] md, vd, cd;
      for (int i = 0; i < 4; i++)
      begin
         take_bits(mem_map_w, ma);
         take_bits(vram_addr_w, va);
         take_bits(mcr_addr_w, ca);
         take_bits(sram_data_w, md);
         take_bits(sram_data_w, vd);
         take_bits(mcr_data_w, cd);
         fork
            port_op(p_mem, 1'b1, {5'b0, ma[16:0]}, {17'b0, md[31:0]});
            port_op(p_vram, 1'b1, {7'b0, va[14:0]}, {17'b0, vd[31:0]});
            port_op(p_mcr, 1'b1, {8'b0, ca[13:0]}, cd[48:0]);
         join
         fork
            port_op(p_mem, 1'b0, {5'b0, ma[16:0]}, '0);
            port_op(p_vram, 1'b0, {7'b0, va[14:0]}, '0);
            port_op(p_mcr, 1'b0, {8'b0, ca[13:0]}, '0);
         join
      end
   endtask

   initial
   begin
      mcr_rd_req  <= 1'b0;
      mcr_wr_req  <= 1'b0;
      mcr_addr    <= '0;
      mcr_wdata   <= '0;
      mem_rd_req  <= 1'b0;
      mem_wr_req  <= 1'b0;
      mem_addr    <= '0;
      mem_wdata   <= '0;
      vram_rd_req <= 1'b0;
      vram_wr_req <= 1'b0;
      vram_addr   <= '0;
      vram_wdata  <= '0;
      exp_mcr     <= '0;
      exp_mem     <= '0;
      exp_vram    <= '0;
      @(negedge reset);

      word_rw_test();
      end_test("word_rw");
      mem_range_test();
      end_test("mem_range");
      mcr_test();
      end_test("mcr_round_trip");
      region_test();
      end_test("region_separation");
      concurrent_test();
      end_test("handshake");
      // pin checks ran over the whole run
      $display("test pin_safety finished with %0d errors", pin_errors);
      tests = tests + 1;

      $display("%0d tests run, %0d errors in total", tests, error_total());
      if (error_total() == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: verification/sram_model.sv
// behavioral 2^18 x 32 sram; writes are sampled on clk while ce_n and we_n are low
`timescale 1ns/1ps
`default_nettype none

module sram_model
   import sram_ctrl_pkg::*;
(
   input  logic                   clk,
   input  sram_pins_t             pins,
   output logic [sram_data_w-1:0] din
);

   logic [sram_data_w-1:0] mem [0:(1<<sram_addr_w)-1];

   // same word rewritten on every clock of the strobe
   always_ff @(posedge clk)
   begin
      if (!pins.ce_n && !pins.we_n)
         mem[pins.addr] <= pins.dout;
   end

   // combinational read path
   assign din = (!pins.ce_n && !pins.oe_n) ? mem[pins.addr] : '0;

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
// 10 ns clock from time zero; reset is high through the first four rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   output logic clk,
   output logic reset
);

   initial
   begin
      clk = 1'b0;
      forever
         #5 clk = ~clk;
   end

   initial
   begin
      reset <= 1'b1;
      repeat (4)
         @(posedge clk);
      reset <= 1'b0;
   end

endmodule

`default_nettype wire

// File: hw/sram_ctrl_top.sv
// one clock for all ports; sram data bus is split into din and dout, tristate kept outside
`timescale 1ns/1ps
`default_nettype none

module sram_ctrl_top
   import sram_ctrl_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   // microcode
   input  logic                   mcr_rd_req,
   input  logic                   mcr_wr_req,
   input  logic [mcr_addr_w-1:0]  mcr_addr,
   input  logic [mcr_data_w-1:0]  mcr_wdata,
   output logic [mcr_data_w-1:0]  mcr_rdata,
   output logic                   mcr_ready,
   output logic                   mcr_done,
   // main memory
   input  logic                   mem_rd_req,
   input  logic                   mem_wr_req,
   input  logic [mem_addr_w-1:0]  mem_addr,
   input  logic [sram_data_w-1:0] mem_wdata,
   output logic [sram_data_w-1:0] mem_rdata,
   output logic                   mem_ready,
   output logic                   mem_done,
   // video memory
   input  logic                   vram_rd_req,
   input  logic                   vram_wr_req,
   input  logic [vram_addr_w-1:0] vram_addr,
   input  logic [sram_data_w-1:0] vram_wdata,
   output logic [sram_data_w-1:0] vram_rdata,
   output logic                   vram_ready,
   output logic                   vram_done,
   // sram
   input  logic [sram_data_w-1:0] sram_din,
   output sram_pins_t             sram
);

   op_t                    op;
   logic                   start, busy, cycle_done;
   logic [sram_data_w-1:0] seq_rdata;
   sram_req_t              mcr_req, mem_req, vram_req, seq_req;
   logic                   mcr_rd_pend, mcr_wr_pend;
   logic                   mem_rd_pend, mem_wr_pend;
   logic                   vram_rd_pend, vram_wr_pend;

   // ------------------------------------------------------------
   // granted access into the sequencer
   // ------------------------------------------------------------
   always_comb
   begin
      case (op)
         op_mcr_rd_hi, op_mcr_rd_lo, op_mcr_wr_hi, op_mcr_wr_lo: seq_req = mcr_req;
         op_mem_rd, op_mem_wr:                                   seq_req = mem_req;
         op_vram_rd, op_vram_wr:                                 seq_req = vram_req;
         default:                                                seq_req = '0;
      endcase
   end

   port_arbiter u_arb (
      .clk, .reset,
      .mcr_rd_pend, .mcr_wr_pend, .mem_rd_pend, .mem_wr_pend,
      .vram_rd_pend, .vram_wr_pend,
      .busy, .cycle_done, .op, .start
   );

   sram_cycle u_cycle (
      .clk, .reset, .start, .req(seq_req), .sram_din,
      .pins(sram), .rdata(seq_rdata), .busy, .cycle_done
   );

   mcr_port u_mcr (
      .clk, .reset, .rd_req(mcr_rd_req), .wr_req(mcr_wr_req),
      .addr(mcr_addr), .wdata(mcr_wdata), .rdata(mcr_rdata),
      .ready(mcr_ready), .done(mcr_done), .rd_pend(mcr_rd_pend), .wr_pend(mcr_wr_pend),
      .op, .cycle_done, .sram_rdata(seq_rdata), .req(mcr_req)
   );

   word_port #(
      .addr_w(mem_addr_w), .map_w(mem_map_w), .prefix_w(mem_prefix_w),
      .prefix(mem_prefix), .rd_op(op_mem_rd), .wr_op(op_mem_wr)
   ) u_mem (
      .clk, .reset, .rd_req(mem_rd_req), .wr_req(mem_wr_req),
      .addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata),
      .ready(mem_ready), .done(mem_done), .rd_pend(mem_rd_pend), .wr_pend(mem_wr_pend),
      .op, .cycle_done, .sram_rdata(seq_rdata), .req(mem_req)
   );

   word_port #(
      .addr_w(vram_addr_w), .map_w(vram_addr_w), .prefix_w(vram_prefix_w),
      .prefix(vram_prefix), .rd_op(op_vram_rd), .wr_op(op_vram_wr)
   ) u_vram (
      .clk, .reset, .rd_req(vram_rd_req), .wr_req(vram_wr_req),
      .addr(vram_addr), .wdata(vram_wdata), .rdata(vram_rdata),
      .ready(vram_ready), .done(vram_done), .rd_pend(vram_rd_pend), .wr_pend(vram_wr_pend),
      .op, .cycle_done, .sram_rdata(seq_rdata), .req(vram_req)
   );

endmodule

`default_nettype wire

// File: hw/word_port.sv
// single-word port; addresses beyond map_w bits read as all ones and writes alias
`timescale 1ns/1ps
`default_nettype none

module word_port
   import sram_ctrl_pkg::*;
#(
   parameter int                  addr_w   = mem_addr_w,
   parameter int                  map_w    = mem_map_w,
   parameter int                  prefix_w = mem_prefix_w,
   parameter logic [prefix_w-1:0] prefix   = mem_prefix,
   parameter op_t                 rd_op    = op_mem_rd,
   parameter op_t                 wr_op    = op_mem_wr
)
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   rd_req,
   input  logic                   wr_req,
   input  logic [addr_w-1:0]      addr,
   input  logic [sram_data_w-1:0] wdata,
   output logic [sram_data_w-1:0] rdata,
   output logic                   ready,
   output logic                   done,
   output logic                   rd_pend,
   output logic                   wr_pend,
   input  op_t                    op,
   input  logic                   cycle_done,
   input  logic [sram_data_w-1:0] sram_rdata,
   output sram_req_t              req
);

   logic [addr_w-1:0]      addr_q;
   logic [sram_data_w-1:0] wdata_q;
   logic                   own_op;
   logic                   in_range;

   assign own_op  = (op == rd_op) || (op == wr_op);
   assign rd_pend = rd_req && !ready;
   assign wr_pend = wr_req && !done;

   always_ff @(posedge clk)
   begin
      if (!own_op && (rd_req || wr_req))
         addr_q <= addr;
      if (!own_op && wr_req)
         wdata_q <= wdata;
   end

   // ------------------------------------------------------------
   // region mapping
   // ------------------------------------------------------------
   generate
      if (addr_w > map_w)
      begin : g_range
         assign in_range = (addr_q[addr_w-1:map_w] == '0);
      end
      else
      begin : g_full
         // whole address reaches the sram
         assign in_range = 1'b1;
      end
   endgenerate

   assign req.addr  = {prefix, addr_q[map_w-1:0]};
   assign req.wdata = wdata_q;
   assign req.write = (op == wr_op);

   always_ff @(posedge clk)
   begin
      if (cycle_done && op == rd_op)
         rdata <= in_range ? sram_rdata : '1;
   end

   // ready/done held until the request drops
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ready <= 1'b0;
         done  <= 1'b0;
      end
      else
      begin
         if (cycle_done && op == rd_op)
            ready <= 1'b1;
         else if (!rd_req)
            ready <= 1'b0;
         if (cycle_done && op == wr_op)
            done <= 1'b1;
         else if (!wr_req)
            done <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: hw/mcr_port.sv
// 49-bit word held in two sram words: hi half at even address zero-extended, lo half at odd
`timescale 1ns/1ps
`default_nettype none

module mcr_port
   import sram_ctrl_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   rd_req,
   input  logic                   wr_req,
   input  logic [mcr_addr_w-1:0]  addr,
   input  logic [mcr_data_w-1:0]  wdata,
   output logic [mcr_data_w-1:0]  rdata,
   output logic                   ready,
   output logic                   done,
   output logic                   rd_pend,
   output logic                   wr_pend,
   input  op_t                    op,
   input  logic                   cycle_done,
   input  logic [sram_data_w-1:0] sram_rdata,
   output sram_req_t              req
);

   logic [mcr_addr_w-1:0] addr_q;
   logic [mcr_data_w-1:0] wdata_q;
   logic                  own_op;
   logic                  is_write;
   logic                  lo_half;

   assign own_op   = (op == op_mcr_rd_hi) || (op == op_mcr_rd_lo) ||
                     (op == op_mcr_wr_hi) || (op == op_mcr_wr_lo);
   assign is_write = (op == op_mcr_wr_hi) || (op == op_mcr_wr_lo);

   // the lo half is launched while the hi completion is still on cycle_done
   assign lo_half  = (op == op_mcr_rd_lo) || (op == op_mcr_wr_lo) || cycle_done;

   assign rd_pend = rd_req && !ready;
   assign wr_pend = wr_req && !done;

   // hold address and data until both halves are through
   always_ff @(posedge clk)
   begin
      if (!own_op && (rd_req || wr_req))
         addr_q <= addr;
      if (!own_op && wr_req)
         wdata_q <= wdata;
   end

   assign req.addr  = {mcr_prefix, addr_q, lo_half};
   assign req.wdata = lo_half ? wdata_q[sram_data_w-1:0] :
                      {{(sram_data_w-mcr_hi_w){1'b0}}, wdata_q[mcr_data_w-1:sram_data_w]};
   assign req.write = is_write;

   // ------------------------------------------------------------
   // read assembly
   // ------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (cycle_done && op == op_mcr_rd_hi)
         rdata[mcr_data_w-1:sram_data_w] <= sram_rdata[mcr_hi_w-1:0];
      if (cycle_done && op == op_mcr_rd_lo)
         rdata[sram_data_w-1:0] <= sram_rdata;
   end

   // completion only after the lo half
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ready <= 1'b0;
         done  <= 1'b0;
      end
      else
      begin
         if (cycle_done && op == op_mcr_rd_lo)
            ready <= 1'b1;
         else if (!rd_req)
            ready <= 1'b0;
         if (cycle_done && op == op_mcr_wr_lo)
            done <= 1'b1;
         else if (!wr_req)
            done <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: hw/sram_cycle.sv
// every access is four clocks with all pins registered; read data sampled at the last clock
`timescale 1ns/1ps
`default_nettype none

module sram_cycle
   import sram_ctrl_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   start,
   input  sram_req_t              req,
   input  logic [sram_data_w-1:0] sram_din,
   output sram_pins_t             pins,
   output logic [sram_data_w-1:0] rdata,
   output logic                   busy,
   output logic                   cycle_done
);

   // 0 idle, 1 and 2 strobe held, 3 sample
   logic [1:0]             phase;
   logic [sram_addr_w-1:0] addr_q;
   logic [sram_data_w-1:0] dout_q;
   logic                   ce_n_q;
   logic                   oe_n_q;
   logic                   we_n_q;

   // ------------------------------------------------------------
   // control and strobes
   // ------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         phase      <= 2'd0;
         ce_n_q     <= 1'b1;
         oe_n_q     <= 1'b1;
         we_n_q     <= 1'b1;
         cycle_done <= 1'b0;
      end
      else
      begin
         cycle_done <= 1'b0;
         case (phase)
            2'd0:
            begin
               if (start)
               begin
                  ce_n_q <= 1'b0;
                  oe_n_q <= req.write;
                  we_n_q <= !req.write;
                  phase  <= 2'd1;
               end
            end
            2'd1: phase <= 2'd2;
            2'd2: phase <= 2'd3;
            default:
            begin
               // release the bus
               ce_n_q     <= 1'b1;
               oe_n_q     <= 1'b1;
               we_n_q     <= 1'b1;
               cycle_done <= 1'b1;
               phase      <= 2'd0;
            end
         endcase
      end
   end

   // address, write data and read capture
   always_ff @(posedge clk)
   begin
      if (phase == 2'd0 && start)
      begin
         addr_q <= req.addr;
         dout_q <= req.wdata;
      end
      if (phase == 2'd3)
         rdata <= sram_din;
   end

   assign busy = (phase != 2'd0);
   assign pins = '{addr: addr_q, dout: dout_q, ce_n: ce_n_q, oe_n: oe_n_q, we_n: we_n_q};

   a_oe_we_excl: assert property (@(posedge clk) disable iff (reset)
      !(!pins.oe_n && !pins.we_n));

   a_strobe_needs_ce: assert property (@(posedge clk) disable iff (reset)
      (!pins.oe_n || !pins.we_n) |-> !pins.ce_n);

endmodule

`default_nettype wire

// File: hw/port_arbiter.sv
// fixed priority, one operation at a time; a microcode access always runs hi then lo half
`timescale 1ns/1ps
`default_nettype none

module port_arbiter
   import sram_ctrl_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic mcr_rd_pend,
   input  logic mcr_wr_pend,
   input  logic mem_rd_pend,
   input  logic mem_wr_pend,
   input  logic vram_rd_pend,
   input  logic vram_wr_pend,
   input  logic busy,
   input  logic cycle_done,
   output op_t  op,
   output logic start
);

   op_t  grant;
   logic any_pend;
   logic start_q;
   logic chain;

   // ------------------------------------------------------------
   // priority pick
   // ------------------------------------------------------------
   always_comb
   begin
      grant = op_idle;
      if (mcr_rd_pend)
         grant = op_mcr_rd_hi;
      else if (mcr_wr_pend)
         grant = op_mcr_wr_hi;
      else if (mem_rd_pend)
         grant = op_mem_rd;
      else if (mem_wr_pend)
         grant = op_mem_wr;
      else if (vram_rd_pend)
         grant = op_vram_rd;
      else if (vram_wr_pend)
         grant = op_vram_wr;
   end

   assign any_pend = (grant != op_idle);

   // lo half issued in the same cycle the hi half completes
   assign chain = cycle_done && (op == op_mcr_rd_hi || op == op_mcr_wr_hi);

   assign start = start_q | chain;

   // ------------------------------------------------------------
   // operation state
   // ------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         op      <= op_idle;
         start_q <= 1'b0;
      end
      else
      begin
         start_q <= 1'b0;
         if (op == op_idle)
         begin
            if (any_pend && !busy)
            begin
               op      <= grant;
               start_q <= 1'b1;
            end
         end
         else if (cycle_done)
         begin
            case (op)
               op_mcr_rd_hi: op <= op_mcr_rd_lo;
               op_mcr_wr_hi: op <= op_mcr_wr_lo;
               default:      op <= op_idle;
            endcase
         end
      end
   end

   // sequencer must be free whenever an access is launched
   a_start_not_busy: assert property (@(posedge clk) disable iff (reset)
      start |-> !busy);

endmodule

`default_nettype wire

// File: hw/sram_ctrl_pkg.sv
// assumes one 2^18 x 32 asynchronous SRAM split into fixed regions for three ports
`default_nettype none

package sram_ctrl_pkg;

   // ------------------------------------------------------------
   // sram geometry
   // ------------------------------------------------------------
   localparam int sram_addr_w = 18;
   localparam int sram_data_w = 32;

   // port widths
   localparam int mcr_addr_w  = 14;
   localparam int mcr_data_w  = 49;
   // upper microcode bits carried in the hi half
   localparam int mcr_hi_w    = mcr_data_w - sram_data_w;
   localparam int mem_addr_w  = 22;
   localparam int mem_map_w   = 17;
   localparam int vram_addr_w = 15;

   // ------------------------------------------------------------
   // region map on the top address bits
   //   0xx  main memory
   //   100  microcode, halfword select in bit 0
   //   110  video memory
   // ------------------------------------------------------------
   localparam int mem_prefix_w  = 1;
   localparam int mcr_prefix_w  = 3;
   localparam int vram_prefix_w = 3;

   localparam logic [mem_prefix_w-1:0]  mem_prefix  = 1'b0;
   localparam logic [mcr_prefix_w-1:0]  mcr_prefix  = 3'b100;
   localparam logic [vram_prefix_w-1:0] vram_prefix = 3'b110;

   // operations granted by the arbiter
   typedef enum logic [3:0] {
      op_idle,
      op_mcr_rd_hi,
      op_mcr_rd_lo,
      op_mcr_wr_hi,
      op_mcr_wr_lo,
      op_mem_rd,
      op_mem_wr,
      op_vram_rd,
      op_vram_wr
   } op_t;

   // one sram access as offered by a port
   typedef struct packed {
      logic [sram_addr_w-1:0] addr;
      logic [sram_data_w-1:0] wdata;
      logic                   write;
   } sram_req_t;

   // registered pins toward the sram, strobes active low
   typedef struct packed {
      logic [sram_addr_w-1:0] addr;
      logic [sram_data_w-1:0] dout;
      logic                   ce_n;
      logic                   oe_n;
      logic                   we_n;
   } sram_pins_t;

endpackage

`default_nettype wire
